// ==== logic/ql_pkg.sv ====
`default_nettype none

package ql_pkg;

  // ====================
  // Widths
  typedef logic [15:0] word_t;          // Bus data word
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] rtc_t;           // Seconds count
  typedef logic [5:0]  reg_off_t;       // Word offset in the I/O area
  typedef logic [3:0]  ipc_cmd_t;
  typedef logic [63:0] kbd_matrix_t;    // Row r at bits 8r+7..8r
  typedef logic [8:0]  pitch_t;
  typedef logic [14:0] duration_t;      // In sound ticks
  typedef logic [63:0] sound_params_t;

  // ====================
  // Register map
  localparam reg_off_t REG_TIMER_HI = 6'd0;
  localparam reg_off_t REG_TIMER_LO = 6'd1;
  localparam reg_off_t REG_IPC_IRQ  = 6'd16;

  // IPC commands handled here
  localparam ipc_cmd_t CMD_STATUS     = 4'd1;
  localparam ipc_cmd_t CMD_READ_KEY   = 4'd8;
  localparam ipc_cmd_t CMD_KEY_ROW    = 4'd9;
  localparam ipc_cmd_t CMD_SET_SOUND  = 4'd10;
  localparam ipc_cmd_t CMD_KILL_SOUND = 4'd11;

  // Bit positions in pending byte and ack field
  localparam int IRQ_BIT_IPC   = 1;
  localparam int IRQ_BIT_VSYNC = 3;

  // Sound timing
  localparam int SOUND_TICK_CYCLES = 1944;  // About 70 us at 27 MHz
  localparam int TONE_STEP_CYCLES  = 8;

  typedef enum logic [1:0] {IPC_CMD, IPC_REPLY, IPC_PARAM, IPC_SOUND} ipc_state_e;
  typedef enum logic [1:0] {BEEP_IDLE, BEEP_TIMED, BEEP_ENDLESS} beep_state_e;

endpackage

`default_nettype wire

// ==== logic/ql_rtc.sv ====
`default_nettype none
`timescale 1ns/10ps

module ql_rtc import ql_pkg::*; #(
  parameter int p_clk_hz = 27000000
) (
  input  wire        clk_cpu,
  input  wire        reset,
  input  wire        i_clr,
  input  wire        i_adj,
  input  wire byte_t i_adj_byte,
  output rtc_t       o_time
);

  localparam int PRE_W = $clog2(p_clk_hz);

  logic [PRE_W-1:0] prescaler;
  logic [1:0]       byte_idx;   // Next byte to adjust

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      prescaler <= '0;
      byte_idx  <= '0;
      o_time    <= '0;
    end else begin
      if (prescaler == PRE_W'(p_clk_hz - 1)) begin  // One second
        prescaler <= '0;
        o_time    <= o_time + 1'b1;
      end else begin
        prescaler <= prescaler + 1'b1;
      end
      // Clear also restarts the current second
      if (i_clr) begin
        prescaler <= '0;
        byte_idx  <= '0;
        o_time    <= '0;
      end
      if (i_adj) begin
        o_time[{byte_idx, 3'b000} +: 8] <= i_adj_byte;
        byte_idx                        <= byte_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/ql_irq_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module ql_irq_ctrl import ql_pkg::*; (
  input  wire        clk_cpu,
  input  wire        reset,
  input  wire        i_vsync,      // Active low
  input  wire        i_key_event,
  input  wire        i_wr,
  input  wire byte_t i_wr_byte,
  output byte_t      o_pending,
  output logic       o_irq_n
);

  logic       vsync_q;
  logic       vsync_irq;
  logic       ipc_irq;
  logic [2:0] irq_mask;
  logic [4:0] irq_ack;

  assign irq_ack = i_wr ? i_wr_byte[4:0] : 5'b0;

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      vsync_q   <= 1'b1;
      vsync_irq <= 1'b0;
      ipc_irq   <= 1'b0;
      irq_mask  <= '0;
    end else begin
      vsync_q <= i_vsync;
      // Ack beats a new set
      if (irq_ack[IRQ_BIT_VSYNC]) vsync_irq <= 1'b0;
      else if (vsync_q && !i_vsync) vsync_irq <= 1'b1;  // Falling edge
      if (irq_ack[IRQ_BIT_IPC]) ipc_irq <= 1'b0;
      else if (i_key_event) ipc_irq <= 1'b1;
      if (i_wr) irq_mask <= i_wr_byte[7:5];
    end
  end

  // Mask shows in the top bits, latches below
  always_comb begin
    o_pending                = '0;
    o_pending[7:5]           = irq_mask;
    o_pending[IRQ_BIT_VSYNC] = vsync_irq;
    o_pending[IRQ_BIT_IPC]   = ipc_irq;
  end

  assign o_irq_n = ~|o_pending[4:0];  // Only latched interrupts request

endmodule

`default_nettype wire

// ==== logic/ql_ipc.sv ====
`default_nettype none
`timescale 1ns/10ps

module ql_ipc import ql_pkg::*; (
  input  wire              clk_cpu,
  input  wire              reset,
  input  wire              i_bit_wr,
  input  wire              i_bit,
  input  wire              i_key_event,
  input  wire              i_key_press,
  input  wire kbd_matrix_t i_kbd_matrix,
  output logic             o_reply_bit,
  output logic             o_sound_start,
  output pitch_t           o_sound_pitch,
  output duration_t        o_sound_duration,
  output logic             o_sound_kill
);

  ipc_state_e    state;
  logic [5:0]    bit_cnt;      // Writes seen in current state
  logic [5:0]    reply_last;   // Reply length minus one
  word_t         reply;
  logic          key_pressed;
  ipc_cmd_t      shift_sr;     // Command or parameter nibble
  ipc_cmd_t      shift_next;
  sound_params_t sound_sr;
  sound_params_t sound_next;
  byte_t         pitch_byte;
  logic          cmd_done;
  logic [2:0]    key_row;
  logic [2:0]    key_col;
  byte_t         row_bits;
  word_t         read_key_reply;

  assign shift_next = {shift_sr[2:0], i_bit};  // MSB first
  assign sound_next = {sound_sr[62:0], i_bit};
  assign cmd_done   = i_bit_wr && (state == IPC_CMD) && (bit_cnt == 6'd3);

  // ====================
  // Key encoder
  always_comb begin
    key_row = 3'd7;
    for (int r = 6; r >= 0; r--) begin
      if (|i_kbd_matrix[8*r +: 8]) key_row = 3'(r);
    end
  end

  // Modifier plus another row 7 key hides cols 0..2
  assign row_bits = i_kbd_matrix[{key_row, 3'b000} +: 8] &
                    ((key_row == 3'd7 && |i_kbd_matrix[58:56] && |i_kbd_matrix[63:59]) ?
                     8'hf8 : 8'hff);

  always_comb begin
    key_col = 3'd7;
    for (int c = 7; c >= 0; c--) begin
      if (row_bits[c]) key_col = 3'(c);
    end
  end

  assign read_key_reply = {4'b0001, 1'b0, i_kbd_matrix[56], i_kbd_matrix[57],
                           i_kbd_matrix[58], 2'b00, ~key_row, key_col};

  // ====================
  // Command engine
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state       <= IPC_CMD;
      bit_cnt     <= '0;
      reply_last  <= '0;
      reply       <= '0;
      key_pressed <= 1'b0;
    end else begin
      if (i_bit_wr) begin
        bit_cnt <= bit_cnt + 1'b1;
        case (state)
          IPC_CMD: begin
            if (bit_cnt == 6'd3) begin
              bit_cnt <= '0;
              case (shift_next)
                CMD_STATUS: begin
                  state       <= IPC_REPLY;
                  reply       <= {7'b0, key_pressed, 8'b0};
                  reply_last  <= 6'd7;
                  key_pressed <= 1'b0;
                end
                CMD_READ_KEY: begin
                  state      <= IPC_REPLY;
                  reply      <= read_key_reply;
                  reply_last <= 6'd15;
                end
                CMD_KEY_ROW:   state <= IPC_PARAM;
                CMD_SET_SOUND: state <= IPC_SOUND;
                default: ;  // Kill goes out as a strobe
              endcase
            end
          end
          IPC_REPLY: begin
            reply <= {reply[14:0], 1'b0};
            if (bit_cnt == reply_last) begin
              state   <= IPC_CMD;
              bit_cnt <= '0;
            end
          end
          IPC_PARAM: begin
            if (bit_cnt == 6'd3) begin  // Row in low 3 bits
              state      <= IPC_REPLY;
              bit_cnt    <= '0;
              reply      <= {i_kbd_matrix[{shift_next[2:0], 3'b000} +: 8], 8'b0};
              reply_last <= 6'd7;
            end
          end
          IPC_SOUND: begin
            if (bit_cnt == 6'd63) begin
              state   <= IPC_CMD;
              bit_cnt <= '0;
            end
          end
        endcase
      end
      if (i_key_event && i_key_press) key_pressed <= 1'b1;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (i_bit_wr) shift_sr <= shift_next;
    if (i_bit_wr && state == IPC_SOUND) sound_sr <= sound_next;
  end

  assign o_reply_bit = reply[15];

  // Sound strobes leave with the last bit
  assign pitch_byte       = sound_next[63:56];
  assign o_sound_start    = i_bit_wr && (state == IPC_SOUND) && (bit_cnt == 6'd63);
  assign o_sound_pitch    = pitch_t'({pitch_byte == 8'd0, pitch_byte}) + 9'd8;  // 0 means 256
  assign o_sound_duration = {sound_next[22:16], sound_next[31:24]};
  assign o_sound_kill     = cmd_done && (shift_next == CMD_KILL_SOUND);

endmodule

`default_nettype wire

// ==== logic/ql_beeper.sv ====
`default_nettype none
`timescale 1ns/10ps

module ql_beeper import ql_pkg::*; (
  input  wire            clk_cpu,
  input  wire            reset,
  input  wire            i_start,
  input  wire pitch_t    i_pitch,
  input  wire duration_t i_duration,
  input  wire            i_kill,
  output logic           o_audio,
  output logic           o_sound_active
);

  localparam int TICK_W = $clog2(SOUND_TICK_CYCLES);
  localparam int TONE_W = $bits(pitch_t) + $clog2(TONE_STEP_CYCLES);

  beep_state_e       state;
  logic [TICK_W-1:0] tick_cnt;
  logic              tick_last;
  logic [TONE_W-1:0] tone_cnt;
  logic [TONE_W-1:0] half_period;
  duration_t         remaining;
  pitch_t            pitch_q;

  assign tick_last   = (tick_cnt == TICK_W'(SOUND_TICK_CYCLES - 1));
  assign half_period = TONE_W'(pitch_q * TONE_STEP_CYCLES);

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state    <= BEEP_IDLE;
      tick_cnt <= '0;
      tone_cnt <= '0;
      o_audio  <= 1'b0;
    end else if (i_kill) begin
      state   <= BEEP_IDLE;
      o_audio <= 1'b0;
    end else if (i_start) begin
      state    <= (i_duration == '0) ? BEEP_ENDLESS : BEEP_TIMED;
      tick_cnt <= '0;
      tone_cnt <= '0;
      o_audio  <= 1'b0;
    end else if (state != BEEP_IDLE) begin
      // Tone
      if (tone_cnt == half_period - 1'b1) begin
        tone_cnt <= '0;
        o_audio  <= ~o_audio;
      end else begin
        tone_cnt <= tone_cnt + 1'b1;
      end
      // Duration
      if (tick_last) begin
        tick_cnt <= '0;
        if (state == BEEP_TIMED && remaining == '0) begin
          state   <= BEEP_IDLE;
          o_audio <= 1'b0;  // Silent once done
        end
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (i_start) begin
      remaining <= i_duration;
      pitch_q   <= i_pitch;
    end else if (state == BEEP_TIMED && tick_last && remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign o_sound_active = (state != BEEP_IDLE);

endmodule

`default_nettype wire

// ==== logic/ql_io_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module ql_io_top import ql_pkg::*; #(
  parameter int p_clk_hz = 27000000
) (
  input  wire         clk_cpu,
  input  wire         reset,
  input  wire reg_off_t    i_bus_off,
  input  wire         i_bus_wr,
  input  wire         i_bus_uds,
  input  wire         i_bus_lds,
  input  wire word_t       i_bus_wdata,
  output word_t       o_bus_rdata,
  input  wire         i_vsync,
  input  wire         i_key_event,
  input  wire         i_key_press,
  input  wire kbd_matrix_t i_kbd_matrix,
  output logic        o_irq_n,
  output logic        o_audio,
  output logic        o_sound_active
);

  logic      rtc_clr;
  logic      rtc_adj;
  logic      ipc_bit_wr;
  logic      irq_wr;
  rtc_t      rtc_time;
  byte_t     irq_pending;
  logic      ipc_reply_bit;
  byte_t     ipc_status;
  logic      sound_start;
  logic      sound_kill;
  pitch_t    sound_pitch;
  duration_t sound_duration;

  // ====================
  // Write strobes
  assign rtc_clr    = i_bus_wr && (i_bus_off == REG_TIMER_HI) && i_bus_uds;
  assign rtc_adj    = i_bus_wr && (i_bus_off == REG_TIMER_HI) && i_bus_lds;
  assign ipc_bit_wr = i_bus_wr && (i_bus_off == REG_TIMER_LO) && i_bus_lds;
  assign irq_wr     = i_bus_wr && (i_bus_off == REG_IPC_IRQ) && i_bus_lds;

  assign ipc_status = {ipc_reply_bit, 7'b0};  // IPC never busy

  // Read data
  always_comb begin
    case (i_bus_off)
      REG_TIMER_HI: o_bus_rdata = rtc_time[31:16];
      REG_TIMER_LO: o_bus_rdata = rtc_time[15:0];
      REG_IPC_IRQ:  o_bus_rdata = {ipc_status, irq_pending};
      default:      o_bus_rdata = '0;
    endcase
  end

  ql_rtc #(.p_clk_hz(p_clk_hz)) u_rtc (
    .clk_cpu    (clk_cpu),
    .reset      (reset),
    .i_clr      (rtc_clr),
    .i_adj      (rtc_adj),
    .i_adj_byte (i_bus_wdata[7:0]),
    .o_time     (rtc_time)
  );

  ql_irq_ctrl u_irq (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_vsync     (i_vsync),
    .i_key_event (i_key_event),
    .i_wr        (irq_wr),
    .i_wr_byte   (i_bus_wdata[7:0]),
    .o_pending   (irq_pending),
    .o_irq_n     (o_irq_n)
  );

  ql_ipc u_ipc (
    .clk_cpu          (clk_cpu),
    .reset            (reset),
    .i_bit_wr         (ipc_bit_wr),
    .i_bit            (i_bus_wdata[1]),  // Data bit 1 carries the IPC bit
    .i_key_event      (i_key_event),
    .i_key_press      (i_key_press),
    .i_kbd_matrix     (i_kbd_matrix),
    .o_reply_bit      (ipc_reply_bit),
    .o_sound_start    (sound_start),
    .o_sound_pitch    (sound_pitch),
    .o_sound_duration (sound_duration),
    .o_sound_kill     (sound_kill)
  );

  ql_beeper u_beeper (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .i_start        (sound_start),
    .i_pitch        (sound_pitch),
    .i_duration     (sound_duration),
    .i_kill         (sound_kill),
    .o_audio        (o_audio),
    .o_sound_active (o_sound_active)
  );

endmodule

`default_nettype wire

// ==== dv/ql_io_properties.sv ====
`default_nettype none
`timescale 1ns/10ps

module ql_io_properties import ql_pkg::*; (
  input wire        clk_cpu,
  input wire        reset,
  input wire byte_t i_pending,
  input wire        i_irq_n,
  input wire        i_audio,
  input wire        i_sound_active,
  input wire        i_sound_kill
);

  int err_count = 0;  // Read by the testbench at the end

  // Latched interrupts drive the request line
  a_irq_n: assert property (@(posedge clk_cpu) disable iff (reset)
    i_irq_n == !(|i_pending[4:0]))
    else begin
      err_count++;
      $error("irq_n does not match pending bits");
    end

  a_quiet: assert property (@(posedge clk_cpu) disable iff (reset)
    !i_sound_active |-> !i_audio)
    else begin
      err_count++;
      $error("audio high while sound idle");
    end

  a_kill: assert property (@(posedge clk_cpu) disable iff (reset)
    i_sound_kill |=> !i_sound_active)
    else begin
      err_count++;
      $error("sound still active after kill");
    end

endmodule

`default_nettype wire

// ==== dv/tb_ql_io.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_ql_io;
  import ql_pkg::*;

  localparam int CLK_HZ = 1000;

  logic        clk_cpu;
  logic        reset;
  reg_off_t    i_bus_off;
  logic        i_bus_wr;
  logic        i_bus_uds;
  logic        i_bus_lds;
  word_t       i_bus_wdata;
  word_t       o_bus_rdata;
  logic        i_vsync;
  logic        i_key_event;
  logic        i_key_press;
  kbd_matrix_t i_kbd_matrix;
  logic        o_irq_n;
  logic        o_audio;
  logic        o_sound_active;

  ql_io_top #(.p_clk_hz(CLK_HZ)) u_dut (.*);

  bind ql_io_top ql_io_properties u_props (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .i_pending      (irq_pending),
    .i_irq_n        (o_irq_n),
    .i_audio        (o_audio),
    .i_sound_active (o_sound_active),
    .i_sound_kill   (sound_kill)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #10 clk_cpu = ~clk_cpu;
  end

  // ====================
  // Reference model
  function automatic word_t expect_read_key(input kbd_matrix_t m);
    logic [2:0] row;
    logic [2:0] col;
    byte_t      rbits;
    logic       found;
    row   = 3'd7;  // No key gives row 7
    found = 1'b0;
    for (int r = 0; r < 7; r++) begin
      if (!found && |m[8*r +: 8]) begin
        row   = r[2:0];
        found = 1'b1;
      end
    end
    rbits = m[8*row +: 8];
    if (row == 3'd7 && |m[58:56] && |m[63:59]) rbits[2:0] = 3'b000;
    col   = 3'd7;
    found = 1'b0;
    for (int c = 0; c < 8; c++) begin
      if (!found && rbits[c]) begin
        col   = c[2:0];
        found = 1'b1;
      end
    end
    return {4'b0001, 1'b0, m[56], m[57], m[58], 2'b00, ~row, col};
  endfunction

  function automatic byte_t expect_key_row(input kbd_matrix_t m, input logic [2:0] row);
    return m[8*row +: 8];
  endfunction

  function automatic int expect_pitch(input sound_params_t p);
    int pb;
    pb = p[63:56];
    if (pb == 0) pb = 256;
    return pb + 8;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Simulation FAILED");
    $fatal(1, "Timed out waiting for %s", what);
  endtask

  // ====================
  // Bus access
  task automatic bus_write(input reg_off_t off, input logic uds, input logic lds,
                           input word_t data);
    @(negedge clk_cpu);
    i_bus_off   = off;
    i_bus_uds   = uds;
    i_bus_lds   = lds;
    i_bus_wdata = data;
    i_bus_wr    = 1'b1;
    @(negedge clk_cpu);
    i_bus_wr  = 1'b0;
    i_bus_uds = 1'b0;
    i_bus_lds = 1'b0;
  endtask

  task automatic bus_read(input reg_off_t off, output word_t data);
    @(negedge clk_cpu);
    i_bus_off = off;
    @(negedge clk_cpu);
    data = o_bus_rdata;
  endtask

  task automatic ipc_send(input ipc_cmd_t cmd, input sound_params_t params, input int nparam);
    for (int i = 3; i >= 0; i--) bus_write(REG_TIMER_LO, 1'b0, 1'b1, {14'b0, cmd[i], 1'b0});
    for (int i = nparam - 1; i >= 0; i--) begin
      bus_write(REG_TIMER_LO, 1'b0, 1'b1, {14'b0, params[i], 1'b0});
    end
  endtask

  task automatic ipc_reply(input int n, output word_t r);
    word_t st;
    r = '0;
    for (int i = 0; i < n; i++) begin
      bus_read(REG_IPC_IRQ, st);
      r = {r[14:0], st[15]};  // Status bit 7
      bus_write(REG_TIMER_LO, 1'b0, 1'b1, 16'h0000);
    end
  endtask

  task automatic key_strobe(input logic press);
    @(negedge clk_cpu);
    i_key_event = 1'b1;
    i_key_press = press;
    @(negedge clk_cpu);
    i_key_event = 1'b0;
    i_key_press = 1'b0;
  endtask

  // ====================
  // Stimulus and checks
  initial begin
    int unsigned   seed;
    int unsigned   dummy;
    byte_t         adj [4];
    word_t         hi;
    word_t         lo;
    word_t         r;
    kbd_matrix_t   m;
    logic [2:0]    row;
    sound_params_t p;
    int            cnt;
    int            high_cnt;
    logic          rose;
    logic          fell;

    seed  = 32'h244b_a2b0;
    dummy = $urandom(seed);
    reset        = 1'b1;
    i_bus_off    = '0;
    i_bus_wr     = 1'b0;
    i_bus_uds    = 1'b0;
    i_bus_lds    = 1'b0;
    i_bus_wdata  = '0;
    i_vsync      = 1'b1;
    i_key_event  = 1'b0;
    i_key_press  = 1'b0;
    i_kbd_matrix = '0;
    repeat (10) @(negedge clk_cpu);
    reset = 1'b0;
    check(o_irq_n, 1'b1, "irq_n after reset");
    check(o_sound_active, 1'b0, "sound idle after reset");

    // Clock reset and byte adjust
    bus_write(REG_TIMER_HI, 1'b1, 1'b0, 16'h0000);
    for (int i = 0; i < 4; i++) begin
      adj[i] = $urandom;
      bus_write(REG_TIMER_HI, 1'b0, 1'b1, {8'h00, adj[i]});
    end
    bus_read(REG_TIMER_HI, hi);
    bus_read(REG_TIMER_LO, lo);
    check({hi, lo}, {adj[3], adj[2], adj[1], adj[0]}, "timer after adjust");
    repeat (1000) @(negedge clk_cpu);
    bus_read(REG_TIMER_HI, hi);
    bus_read(REG_TIMER_LO, lo);
    check({hi, lo}, {adj[3], adj[2], adj[1], adj[0]} + 32'd1, "timer after one second");

    // Interrupts
    @(negedge clk_cpu);
    i_vsync = 1'b0;
    bus_read(REG_IPC_IRQ, r);
    check(r[7:0], 8'h08, "vsync pending");
    check(o_irq_n, 1'b0, "irq_n on vsync");
    i_vsync = 1'b1;
    bus_write(REG_IPC_IRQ, 1'b0, 1'b1, 16'h0008);
    key_strobe(1'b0);
    bus_read(REG_IPC_IRQ, r);
    check(r[7:0], 8'h02, "key pending");
    check(o_irq_n, 1'b0, "irq_n on key event");
    bus_write(REG_IPC_IRQ, 1'b0, 1'b1, 16'h0002);
    bus_read(REG_IPC_IRQ, r);
    check(r[7:0], 8'h00, "pending after ack");
    check(o_irq_n, 1'b1, "irq_n after ack");
    bus_write(REG_IPC_IRQ, 1'b0, 1'b1, 16'h00e0);  // Mask bits only
    bus_read(REG_IPC_IRQ, r);
    check(r[7:0], 8'he0, "mask readback");
    check(o_irq_n, 1'b1, "mask alone raises no request");
    bus_write(REG_IPC_IRQ, 1'b0, 1'b1, 16'h0000);

    // Status and read key
    ipc_send(CMD_STATUS, '0, 0);
    ipc_reply(8, r);
    check(r[0], 1'b0, "status flag ignores release event");
    m = kbd_matrix_t'(1) << ($urandom % 64);
    i_kbd_matrix = m;
    key_strobe(1'b1);
    ipc_send(CMD_STATUS, '0, 0);
    ipc_reply(8, r);
    check(r[0], 1'b1, "status key flag set");
    ipc_send(CMD_STATUS, '0, 0);
    ipc_reply(8, r);
    check(r[0], 1'b0, "status key flag cleared");
    m = (kbd_matrix_t'(1) << 61) | (kbd_matrix_t'(1) << 56);  // Shift plus a row 7 key
    i_kbd_matrix = m;
    ipc_send(CMD_READ_KEY, '0, 0);
    ipc_reply(16, r);
    check(r, expect_read_key(m), "read key with modifier");
    for (int i = 0; i < 8; i++) begin
      m = (kbd_matrix_t'(1) << ($urandom % 64)) | (kbd_matrix_t'($urandom % 8) << 56);
      i_kbd_matrix = m;
      ipc_send(CMD_READ_KEY, '0, 0);
      ipc_reply(16, r);
      check(r, expect_read_key(m), "read key reply");
    end

    // Key row
    m   = {$urandom, $urandom};
    row = $urandom % 8;
    i_kbd_matrix = m;
    ipc_send(CMD_KEY_ROW, {60'b0, 1'b0, row}, 4);
    ipc_reply(8, r);
    check(r[7:0], expect_key_row(m, row), "key row reply");

    // Timed sound, duration 2
    p = {$urandom, $urandom};
    p[31:24] = 8'd2;
    p[22:16] = 7'd0;
    ipc_send(CMD_SET_SOUND, p, 64);
    check(o_sound_active, 1'b1, "sound starts");
    cnt      = 0;
    high_cnt = 0;
    rose     = 1'b0;
    fell     = 1'b0;
    while (o_sound_active) begin
      if (o_audio && !fell) begin
        high_cnt++;
        rose = 1'b1;
      end else if (rose) begin
        fell = 1'b1;
      end
      cnt++;
      if (cnt > 4 * SOUND_TICK_CYCLES) fail_timeout("timed sound to end");
      @(negedge clk_cpu);
    end
    check((cnt >= 3 * SOUND_TICK_CYCLES - 4) && (cnt <= 3 * SOUND_TICK_CYCLES + 4), 1'b1,
          "timed sound length");
    check(high_cnt, expect_pitch(p) * TONE_STEP_CYCLES, "tone half-period");
    check(o_audio, 1'b0, "audio low after sound");

    // Endless sound then kill
    p = {$urandom, $urandom};
    p[31:24] = 8'd0;
    p[22:16] = 7'd0;
    ipc_send(CMD_SET_SOUND, p, 64);
    repeat (11 * SOUND_TICK_CYCLES) begin
      @(negedge clk_cpu);
      check(o_sound_active, 1'b1, "endless sound keeps playing");
    end
    ipc_send(CMD_KILL_SOUND, '0, 0);
    check(o_sound_active, 1'b0, "sound off after kill");
    check(o_audio, 1'b0, "audio low after kill");

    repeat (5) @(negedge clk_cpu);
    if (u_dut.u_props.err_count != 0) begin
      $display("Simulation FAILED");
      $fatal(1, "Bound assertions failed %0d times", u_dut.u_props.err_count);
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/ql_pkg.sv
logic/ql_rtc.sv
logic/ql_irq_ctrl.sv
logic/ql_ipc.sv
logic/ql_beeper.sv
logic/ql_io_top.sv
dv/ql_io_properties.sv
dv/tb_ql_io.sv
